// ==== flist.f ====
+incdir+bench
hw/rx_pkg.sv
hw/wb_if.sv
hw/sfd_strip.sv
hw/crc_strip.sv
hw/copy_writer.sv
hw/majority_voter.sv
hw/wb_arbiter.sv
hw/frame_ram.sv
hw/rx_vote_top.sv
bench/tb_rx_vote.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_rx_vote \
	-f flist.f

./obj_dir/Vtb_rx_vote | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

// ==== bench/tb_frame_tasks.svh ====
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

// reflected crc32 over the payload and inverted for the fcs field
function automatic logic [31:0] frame_fcs(input int idx);
	logic [31:0] crc;
	crc = 32'hFFFFFFFF;
	for (int i = 0; i < copy_len[idx]; i++) begin
		crc = crc ^ {24'h000000, copy_buf[idx][i]};
		for (int b = 0; b < 8; b++) begin
			crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
		end
	end
	return ~crc;
endfunction

// reference vote sets a bit when more than half the copies have it
function automatic logic [7:0] vote_byte(input int n, input int k);
	int ones;
	logic [7:0] v;
	for (int b = 0; b < 8; b++) begin
		ones = 0;
		for (int c = 0; c < n; c++) begin
			if (copy_buf[c][k][b]) ones++;
		end
		v[b] = (2 * ones > n);
	end
	return v;
endfunction

task automatic fill_random(input int idx, input int len);
	copy_len[idx] = len;
	for (int i = 0; i < len; i++) begin
		copy_buf[idx][i] = 8'($random(seed));
	end
endtask

task automatic duplicate(input int dst, input int src);
	copy_len[dst] = copy_len[src];
	for (int i = 0; i < copy_len[src]; i++) begin
		copy_buf[dst][i] = copy_buf[src][i];
	end
endtask

// sends preamble, sfd, payload and fcs lsb first at one byte per BYTE_GAP cycles
task automatic send_copy(input int idx, input bit bad_fcs, input bit with_sfd);
	logic [7:0] line_bytes [$];
	logic [31:0] fcs;
	fcs = frame_fcs(idx);
	if (bad_fcs) begin
		fcs = fcs ^ 32'h00000100;
	end
	repeat (7) line_bytes.push_back(8'h55);
	if (with_sfd) begin
		line_bytes.push_back(SFD_BYTE);
	end
	for (int i = 0; i < copy_len[idx]; i++) begin
		line_bytes.push_back(copy_buf[idx][i]);
	end
	for (int i = 0; i < 4; i++) begin
		line_bytes.push_back(fcs[8*i +: 8]);
	end
	@(posedge clk125MHz);
	rx_enable <= 1'b1;
	foreach (line_bytes[i]) begin
		rx_data <= line_bytes[i];
		rx_valid <= 1'b1;
		@(posedge clk125MHz);
		rx_valid <= 1'b0;
		repeat (BYTE_GAP - 1) @(posedge clk125MHz);
	end
	rx_enable <= 1'b0;
	repeat (FRAME_GAP) @(posedge clk125MHz);
endtask

task automatic snap_counts();
	good_base = good_frames;
	bad_base = bad_frames;
	drop_base = dropped_frames;
	frame_base = frames_out;
endtask

task automatic check_counts(input int dg, input int db, input int dd);
	if (good_frames != good_base + 16'(dg)) begin
		$display("Mismatch good_frames: got %h expected %h", good_frames, good_base + 16'(dg));
		mismatch_count++;
	end
	if (bad_frames != bad_base + 16'(db)) begin
		$display("Mismatch bad_frames: got %h expected %h", bad_frames, bad_base + 16'(db));
		mismatch_count++;
	end
	if (dropped_frames != drop_base + 16'(dd)) begin
		$display("Mismatch dropped_frames: got %h expected %h",
			dropped_frames, drop_base + 16'(dd));
		mismatch_count++;
	end
endtask

// waits for the next voted frame and compares it with the vote of copies 0..n-1
task automatic expect_vote(input int n, input logic exp_err);
	int cycles;
	exp_len = copy_len[0];
	for (int k = 0; k < exp_len; k++) begin
		exp_buf[k] = vote_byte(n, k);
	end
	cycles = 0;
	while (frames_out < frame_base + 1 && cycles < VOTE_TIMEOUT) begin
		@(posedge clk125MHz);
		cycles++;
	end
	if (frames_out < frame_base + 1) begin
		$display("no voted frame came out within %0d cycles", VOTE_TIMEOUT);
		other_count++;
	end else begin
		if (out_q.size() - out_base != exp_len) begin
			$display("Mismatch out_len: got %h expected %h", out_q.size() - out_base, exp_len);
			mismatch_count++;
		end
		for (int k = 0; k < exp_len && out_base + k < out_q.size(); k++) begin
			if (out_q[out_base + k] !== exp_buf[k]) begin
				$display("Mismatch out_data[%0d]: got %h expected %h",
					k, out_q[out_base + k], exp_buf[k]);
				mismatch_count++;
			end
		end
		if (last_vote_error !== exp_err) begin
			$display("Mismatch vote_error: got %h expected %h", last_vote_error, exp_err);
			mismatch_count++;
		end
		out_base = out_q.size();
	end
endtask

task automatic single_copy_passes();
	@(posedge clk125MHz);
	redundancy <= RED_1;
	snap_counts();
	fill_random(0, 20);
	send_copy(0, 1'b0, 1'b1);
	expect_vote(1, 1'b0);
	check_counts(1, 0, 0);
endtask

task automatic three_copies_outvote_flips();
	@(posedge clk125MHz);
	redundancy <= RED_3;
	snap_counts();
	fill_random(0, 28);
	duplicate(1, 0);
	duplicate(2, 0);
	// fcs is built after the flips so copy 1 still has a good crc
	for (int i = 0; i < 28; i++) begin
		copy_buf[1][i] = copy_buf[1][i] ^ 8'($random(seed));
	end
	for (int c = 0; c < 3; c++) begin
		send_copy(c, 1'b0, 1'b1);
	end
	expect_vote(3, 1'b0);
	check_counts(3, 0, 0);
endtask

task automatic five_copies_outvote_two();
	@(posedge clk125MHz);
	redundancy <= RED_5;
	snap_counts();
	fill_random(0, 36);
	for (int c = 1; c < 5; c++) begin
		duplicate(c, 0);
	end
	copy_buf[1][3] = copy_buf[1][3] ^ (8'($random(seed)) | 8'h01);
	copy_buf[3][17] = copy_buf[3][17] ^ (8'($random(seed)) | 8'h80);
	for (int c = 0; c < 5; c++) begin
		send_copy(c, 1'b0, 1'b1);
	end
	expect_vote(5, 1'b0);
	check_counts(5, 0, 0);
endtask

task automatic bad_fcs_not_a_copy();
	@(posedge clk125MHz);
	redundancy <= RED_3;
	snap_counts();
	fill_random(0, 24);
	duplicate(1, 0);
	duplicate(2, 0);
	send_copy(0, 1'b0, 1'b1);
	send_copy(1, 1'b1, 1'b1);
	send_copy(1, 1'b0, 1'b1);
	send_copy(2, 1'b0, 1'b1);
	expect_vote(3, 1'b0);
	check_counts(3, 1, 0);
endtask

task automatic length_mismatch_flagged();
	@(posedge clk125MHz);
	redundancy <= RED_3;
	snap_counts();
	fill_random(1, 24);
	duplicate(2, 1);
	duplicate(0, 1);
	// first copy is three bytes short and sets the output length
	copy_len[0] = 21;
	for (int c = 0; c < 3; c++) begin
		send_copy(c, 1'b0, 1'b1);
	end
	expect_vote(3, 1'b1);
	check_counts(3, 0, 0);
endtask

task automatic busy_and_sfdless_frames();
	@(posedge clk125MHz);
	redundancy <= RED_3;
	snap_counts();
	fill_random(0, 32);
	for (int c = 1; c < 4; c++) begin
		duplicate(c, 0);
	end
	for (int c = 0; c < 3; c++) begin
		send_copy(c, 1'b0, 1'b1);
	end
	// starts while the vote of the group above is still reading
	send_copy(3, 1'b0, 1'b1);
	expect_vote(3, 1'b0);
	check_counts(4, 0, 1);
	snap_counts();
	fill_random(4, 16);
	// neither preamble nor sfd so the hunt gives up on this frame
	copy_buf[4][0] = 8'h00;
	send_copy(4, 1'b0, 1'b0);
	repeat (200) @(posedge clk125MHz);
	check_counts(0, 0, 0);
	if (frames_out != frame_base) begin
		$display("Mismatch frames_out: got %h expected %h", frames_out, frame_base);
		mismatch_count++;
	end
	if (out_q.size() != out_base) begin
		$display("output bytes appeared after a frame without SFD");
		other_count++;
	end
endtask

`endif

// ==== bench/tb_rx_vote.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rx_vote import rx_pkg::*; ();

	localparam int BYTE_GAP = 10;
	localparam int FRAME_GAP = 12;
	localparam int VOTE_TIMEOUT = 4000;
	// 21 copies on the wire, at most 48 bytes each
	localparam int WATCHDOG_CYCLES = 21 * 48 * 400 + 20000;

	logic clk125MHz;
	logic reset;
	logic [7:0] rx_data;
	logic rx_valid;
	logic rx_enable;
	logic [1:0] redundancy;
	wire [7:0] out_data;
	wire out_valid;
	wire out_last;
	wire vote_error;
	wire [15:0] good_frames;
	wire [15:0] bad_frames;
	wire [15:0] dropped_frames;

	// payload of every copy as it goes on the wire
	logic [7:0] copy_buf [MAX_COPIES][128];
	int copy_len [MAX_COPIES];
	logic [7:0] exp_buf [128];
	int exp_len;
	logic [7:0] out_q [$];
	int out_base = 0;
	int frames_out = 0;
	int frame_base = 0;
	logic last_vote_error = 1'b0;
	int monitor_errors = 0;
	int mismatch_count = 0;
	int other_count = 0;
	integer seed;
	logic [15:0] good_base;
	logic [15:0] bad_base;
	logic [15:0] drop_base;

	rx_vote_top rx_vote_top_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_enable(rx_enable),
		.redundancy(redundancy),
		.out_data(out_data), .out_valid(out_valid), .out_last(out_last),
		.vote_error(vote_error), .good_frames(good_frames),
		.bad_frames(bad_frames), .dropped_frames(dropped_frames)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	// voted bytes, one frame per out_last
	always @(posedge clk125MHz) begin
		if (out_valid) begin
			out_q.push_back(out_data);
			if (out_last) begin
				last_vote_error = vote_error;
				frames_out = frames_out + 1;
			end
		end
		if (vote_error && !(out_valid && out_last)) begin
			$display("vote_error went high outside the last output byte");
			monitor_errors = monitor_errors + 1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk125MHz);
		$display("watchdog expired after %0d cycles, test sequence did not end", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		seed = 32'h875a;
		reset <= 1'b1;
		rx_data <= 8'h00;
		rx_valid <= 1'b0;
		rx_enable <= 1'b0;
		redundancy <= RED_1;
		repeat (5) @(posedge clk125MHz);
		reset <= 1'b0;
		repeat (4) @(posedge clk125MHz);
		single_copy_passes();
		three_copies_outvote_flips();
		five_copies_outvote_two();
		bad_fcs_not_a_copy();
		length_mismatch_flagged();
		busy_and_sfdless_frames();
		other_count = other_count + monitor_errors;
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	`include "tb_frame_tasks.svh"

endmodule

`default_nettype wire

// ==== hw/rx_vote_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_vote_top import rx_pkg::*; (
	input wire clk125MHz,
	input wire reset,
	input wire [7:0] rx_data,
	input wire rx_valid,
	input wire rx_enable,
	input wire [1:0] redundancy,
	output wire [7:0] out_data,
	output wire out_valid,
	output wire out_last,
	output wire vote_error,
	output wire [15:0] good_frames,
	output wire [15:0] bad_frames,
	output wire [15:0] dropped_frames
);

	wire [7:0] pay_data;
	wire pay_strobe;
	wire pay_start;
	wire pay_end;
	wire [7:0] frm_data;
	wire frm_strobe;
	wire frm_start;
	wire frm_end;
	wire crc_ok;
	wire group_ready;
	wire [2:0] group_copies;
	wire vote_done;

	wb_if wb_w ();
	wb_if wb_v ();
	wb_if wb_m ();

	sfd_strip sfd_strip_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.rx_data(rx_data), .rx_valid(rx_valid), .rx_enable(rx_enable),
		.pay_data(pay_data), .pay_strobe(pay_strobe),
		.pay_start(pay_start), .pay_end(pay_end)
	);

	crc_strip crc_strip_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.pay_data(pay_data), .pay_strobe(pay_strobe),
		.pay_start(pay_start), .pay_end(pay_end),
		.frm_data(frm_data), .frm_strobe(frm_strobe),
		.frm_start(frm_start), .frm_end(frm_end), .crc_ok(crc_ok),
		.good_frames(good_frames), .bad_frames(bad_frames)
	);

	copy_writer copy_writer_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.redundancy(redundancy_e'(redundancy)),
		.frm_data(frm_data), .frm_strobe(frm_strobe),
		.frm_start(frm_start), .frm_end(frm_end), .crc_ok(crc_ok),
		.vote_done(vote_done), .group_ready(group_ready),
		.group_copies(group_copies), .dropped_frames(dropped_frames),
		.wb(wb_w.master)
	);

	majority_voter majority_voter_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.group_ready(group_ready), .group_copies(group_copies),
		.vote_done(vote_done), .out_data(out_data), .out_valid(out_valid),
		.out_last(out_last), .vote_error(vote_error),
		.wb(wb_v.master)
	);

	wb_arbiter wb_arbiter_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.wb_w(wb_w.slave), .wb_v(wb_v.slave), .wb_m(wb_m.master)
	);

	frame_ram frame_ram_i (
		.clk125MHz(clk125MHz), .reset(reset),
		.wb(wb_m.slave)
	);

endmodule

`default_nettype wire

// ==== hw/frame_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_ram import rx_pkg::*; (
	input wire clk125MHz,
	input wire reset,
	wb_if.slave wb
);

	logic [7:0] mem [2**ADDR_W];
	logic req;

	// one ack per strobe, even if stb is still high on the ack cycle
	assign req = wb.cyc && wb.stb && !wb.ack;

	always_ff @(posedge clk125MHz) begin
		if (reset) wb.ack <= 1'b0;
		else wb.ack <= req;
	end

	always_ff @(posedge clk125MHz) begin
		if (req) begin
			if (wb.we) mem[wb.adr] <= wb.dat_w;
			wb.dat_r <= mem[wb.adr];
		end
	end

endmodule

`default_nettype wire

// ==== hw/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
	input wire clk125MHz,
	input wire reset,
	wb_if.slave wb_w,
	wb_if.slave wb_v,
	wb_if.master wb_m
);

	logic gnt_w;
	logic gnt_v;

	// writer first, grant held until its cyc drops
	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			gnt_w <= 1'b0;
			gnt_v <= 1'b0;
		end else if (gnt_w) begin
			gnt_w <= wb_w.cyc;
		end else if (gnt_v) begin
			gnt_v <= wb_v.cyc;
		end else if (wb_w.cyc) begin
			gnt_w <= 1'b1;
		end else if (wb_v.cyc) begin
			gnt_v <= 1'b1;
		end
	end

	always_comb begin
		wb_m.adr = gnt_w ? wb_w.adr : wb_v.adr;
		wb_m.dat_w = gnt_w ? wb_w.dat_w : wb_v.dat_w;
		wb_m.we = gnt_w ? wb_w.we : wb_v.we;
		wb_m.cyc = (gnt_w && wb_w.cyc) || (gnt_v && wb_v.cyc);
		wb_m.stb = (gnt_w && wb_w.stb) || (gnt_v && wb_v.stb);
	end

	assign wb_w.ack = gnt_w && wb_m.ack;
	assign wb_v.ack = gnt_v && wb_m.ack;
	assign wb_w.dat_r = gnt_w ? wb_m.dat_r : 8'h00;
	assign wb_v.dat_r = gnt_v ? wb_m.dat_r : 8'h00;

endmodule

`default_nettype wire

// ==== hw/majority_voter.sv ====
`timescale 1ns/1ps
`default_nettype none

module majority_voter import rx_pkg::*; (
	input wire clk125MHz,
	input wire reset,
	input wire group_ready,
	input wire [2:0] group_copies,
	output logic vote_done,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_last,
	output logic vote_error,
	wb_if.master wb
);

	vote_state_e state;
	logic [2:0] ncopies;
	logic [2:0] c;
	logic [SLOT_BITS-1:0] k;
	logic [SLOT_BITS-1:0] len0;
	logic [SLOT_BITS-1:0] len_n;
	logic mismatch;
	logic last_byte;
	logic [2:0] ones [8];
	logic [2:0] ones_n [8];
	logic [7:0] vote_n;

	// read only master
	assign wb.we = 1'b0;
	assign wb.dat_w = 8'h00;

	assign len_n = (c == '0) ? wb.dat_r[SLOT_BITS-1:0] : len0;
	assign last_byte = (k == len0 - 7'd1);

	// ones per bit, first copy restarts the count
	always_comb begin
		for (int b = 0; b < 8; b++) begin
			ones_n[b] = ((c == '0) ? 3'd0 : ones[b]) + {2'b00, wb.dat_r[b]};
			vote_n[b] = {ones_n[b], 1'b0} > {1'b0, ncopies};
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= V_IDLE;
			vote_done <= 1'b0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
			vote_error <= 1'b0;
			wb.cyc <= 1'b0;
			wb.stb <= 1'b0;
			c <= '0;
			k <= '0;
			mismatch <= 1'b0;
		end else begin
			vote_done <= 1'b0;
			case (state)
				V_IDLE: if (group_ready) begin
					ncopies <= group_copies;
					c <= '0;
					mismatch <= 1'b0;
					wb.cyc <= 1'b1;
					wb.stb <= 1'b1;
					wb.adr <= '0;
					state <= V_READ_LEN;
				end
				V_READ_LEN: if (wb.ack) begin
					wb.stb <= 1'b0;
					len0 <= len_n;
					if (c != '0 && wb.dat_r != {1'b0, len0}) mismatch <= 1'b1;
					if (c != ncopies - 3'd1) begin
						c <= c + 3'd1;
						wb.adr <= {c + 3'd1, 7'd0};
					end else if (len_n == '0) begin
						// nothing stored, release the group
						wb.cyc <= 1'b0;
						vote_done <= 1'b1;
						state <= V_IDLE;
					end else begin
						c <= '0;
						k <= '0;
						wb.adr <= {3'd0, 7'd1};
						state <= V_READ_BYTE;
					end
				end else if (!wb.stb) begin
					wb.stb <= 1'b1;
				end
				V_READ_BYTE: if (wb.ack) begin
					wb.stb <= 1'b0;
					ones <= ones_n;
					if (c == ncopies - 3'd1) begin
						out_data <= vote_n;
						out_valid <= 1'b1;
						out_last <= last_byte;
						vote_error <= mismatch && last_byte;
						state <= V_EMIT;
					end else begin
						c <= c + 3'd1;
						wb.adr <= {c + 3'd1, k + 7'd1};
					end
				end else if (!wb.stb) begin
					wb.stb <= 1'b1;
				end
				V_EMIT: begin
					out_valid <= 1'b0;
					out_last <= 1'b0;
					vote_error <= 1'b0;
					if (out_last) begin
						wb.cyc <= 1'b0;
						vote_done <= 1'b1;
						state <= V_IDLE;
					end else begin
						k <= k + 7'd1;
						c <= '0;
						wb.adr <= {3'd0, k + 7'd2};
						state <= V_READ_BYTE;
					end
				end
				default: state <= V_IDLE;
			endcase
		end
	end

	a_no_output_in_idle: assert property (@(posedge clk125MHz) disable iff (reset)
		out_valid |-> state != V_IDLE);

endmodule

`default_nettype wire

// ==== hw/copy_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module copy_writer import rx_pkg::*; (
	input wire clk125MHz,
	input wire reset,
	input var redundancy_e redundancy,
	input wire [7:0] frm_data,
	input wire frm_strobe,
	input wire frm_start,
	input wire frm_end,
	input wire crc_ok,
	input wire vote_done,
	output logic group_ready,
	output logic [2:0] group_copies,
	output logic [15:0] dropped_frames,
	wb_if.master wb
);

	wr_state_e state;
	logic [2:0] copies;
	logic [SLOT_BITS-1:0] len;
	logic overrun;
	logic too_long;
	logic crc_good;
	logic len_sent;
	logic drop_now;

	assign wb.we = 1'b1;

	// missed start, vote busy, or lost bytes
	assign drop_now = (frm_end && (state == WR_WAIT_VOTE || state == WR_IDLE)) ||
		(state == WR_CLOSE && !wb.cyc && crc_good && (overrun || too_long));

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= WR_IDLE;
			copies <= '0;
			group_copies <= 3'd1;
			group_ready <= 1'b0;
			wb.cyc <= 1'b0;
			wb.stb <= 1'b0;
			len <= '0;
			overrun <= 1'b0;
			too_long <= 1'b0;
			crc_good <= 1'b0;
			len_sent <= 1'b0;
		end else begin
			group_ready <= 1'b0;
			if (wb.ack) begin
				wb.cyc <= 1'b0;
				wb.stb <= 1'b0;
			end
			case (state)
				WR_IDLE: if (frm_start) begin
					// group size fixed at first copy
					if (copies == '0) begin
						case (redundancy)
							RED_3: group_copies <= 3'd3;
							RED_5: group_copies <= 3'(MAX_COPIES);
							default: group_copies <= 3'd1;
						endcase
					end
					len <= '0;
					overrun <= 1'b0;
					too_long <= 1'b0;
					len_sent <= 1'b0;
					state <= WR_STORE;
				end
				WR_STORE: begin
					if (frm_strobe) begin
						if (wb.cyc) begin
							overrun <= 1'b1;
						end else if (len == SLOT_BITS'(MAX_PAYLOAD)) begin
							too_long <= 1'b1;
						end else begin
							wb.cyc <= 1'b1;
							wb.stb <= 1'b1;
							wb.adr <= {copies, len + 7'd1};
							wb.dat_w <= frm_data;
							len <= len + 7'd1;
						end
					end
					if (frm_end) begin
						crc_good <= crc_ok;
						state <= WR_CLOSE;
					end
				end
				WR_CLOSE: if (!wb.cyc) begin
					if (!crc_good || overrun || too_long) begin
						// slot gets reused by next frame
						state <= WR_IDLE;
					end else if (!len_sent) begin
						wb.cyc <= 1'b1;
						wb.stb <= 1'b1;
						wb.adr <= {copies, 7'd0};
						wb.dat_w <= {1'b0, len};
						len_sent <= 1'b1;
					end else begin
						copies <= copies + 3'd1;
						if (copies + 3'd1 == group_copies) begin
							group_ready <= 1'b1;
							state <= WR_WAIT_VOTE;
						end else begin
							state <= WR_IDLE;
						end
					end
				end
				WR_WAIT_VOTE: if (vote_done) begin
					copies <= '0;
					state <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (reset) dropped_frames <= '0;
		else if (drop_now && dropped_frames != 16'hFFFF) dropped_frames <= dropped_frames + 16'd1;
	end

	a_no_stb_on_ack: assert property (@(posedge clk125MHz) disable iff (reset)
		$rose(wb.stb) |-> !wb.ack);

endmodule

`default_nettype wire

// ==== hw/crc_strip.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc_strip import rx_pkg::*; (
	input wire clk125MHz,
	input wire reset,
	input wire [7:0] pay_data,
	input wire pay_strobe,
	input wire pay_start,
	input wire pay_end,
	output logic [7:0] frm_data,
	output logic frm_strobe,
	output logic frm_start,
	output logic frm_end,
	output logic crc_ok,
	output logic [15:0] good_frames,
	output logic [15:0] bad_frames
);

	logic [31:0] crc;
	logic [31:0] crc_n;
	logic [7:0] dly [4];
	logic [2:0] fill;
	logic res_match;

	// lsb first, one bit per step
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			r = (r[0] ^ d[i]) ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
		end
		return r;
	endfunction

	// last byte can arrive together with pay_end
	assign crc_n = pay_strobe ? crc_byte(crc, pay_data) : crc;
	assign res_match = (crc_n == CRC_RESIDUE);

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			crc <= '1;
			fill <= '0;
			frm_strobe <= 1'b0;
			frm_start <= 1'b0;
			frm_end <= 1'b0;
			crc_ok <= 1'b0;
			good_frames <= '0;
			bad_frames <= '0;
		end else begin
			frm_strobe <= pay_strobe && (fill == 3'd4);
			frm_start <= pay_start;
			frm_end <= pay_end;
			if (pay_start) begin
				crc <= '1;
				fill <= '0;
			end else begin
				crc <= crc_n;
				if (pay_strobe && fill != 3'd4) fill <= fill + 3'd1;
			end
			if (pay_end) begin
				crc_ok <= res_match;
				if (res_match && good_frames != 16'hFFFF) good_frames <= good_frames + 16'd1;
				if (!res_match && bad_frames != 16'hFFFF) bad_frames <= bad_frames + 16'd1;
			end
		end
	end

	// four byte delay holds back the fcs
	always_ff @(posedge clk125MHz) begin
		if (pay_strobe) begin
			dly[0] <= pay_data;
			dly[1] <= dly[0];
			dly[2] <= dly[1];
			dly[3] <= dly[2];
			frm_data <= dly[3];
		end
	end

endmodule

`default_nettype wire

// ==== hw/sfd_strip.sv ====
`timescale 1ns/1ps
`default_nettype none

module sfd_strip import rx_pkg::*; (
	input wire clk125MHz,
	input wire reset,
	input wire [7:0] rx_data,
	input wire rx_valid,
	input wire rx_enable,
	output logic [7:0] pay_data,
	output logic pay_strobe,
	output logic pay_start,
	output logic pay_end
);

	sfd_state_e state;

	// end of payload as soon as the frame window closes
	assign pay_end = (state == SFD_PAYLOAD) && !rx_enable;

	always_ff @(posedge clk125MHz) begin
		if (reset) begin
			state <= SFD_HUNT;
			pay_strobe <= 1'b0;
			pay_start <= 1'b0;
		end else begin
			pay_strobe <= 1'b0;
			pay_start <= 1'b0;
			case (state)
				SFD_HUNT: if (rx_enable && rx_valid) begin
					if (rx_data == SFD_BYTE) begin
						state <= SFD_PAYLOAD;
						pay_start <= 1'b1;
					end else if (rx_data != PRE_BYTE) begin
						// not preamble so skip the rest of the frame
						state <= SFD_SKIP;
					end
				end
				SFD_PAYLOAD: if (!rx_enable) begin
					state <= SFD_HUNT;
				end else if (rx_valid) begin
					pay_data <= rx_data;
					pay_strobe <= 1'b1;
				end
				SFD_SKIP: if (!rx_enable) state <= SFD_HUNT;
				default: state <= SFD_HUNT;
			endcase
		end
	end

	a_strobe_in_payload: assert property (@(posedge clk125MHz) disable iff (reset)
		pay_strobe |-> state == SFD_PAYLOAD);

endmodule

`default_nettype wire

// ==== hw/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_if import rx_pkg::*; ();

	logic [ADDR_W-1:0] adr;
	logic [7:0] dat_w;
	logic [7:0] dat_r;
	logic we;
	logic stb;
	logic cyc;
	logic ack;

	modport master (
		output adr, dat_w, we, stb, cyc,
		input dat_r, ack
	);

	modport slave (
		input adr, dat_w, we, stb, cyc,
		output dat_r, ack
	);

endinterface

`default_nettype wire

// ==== hw/rx_pkg.sv ====
`default_nettype none

package rx_pkg;

	// frame memory layout
	localparam int SLOT_BITS = 7;
	localparam int MAX_COPIES = 5;
	localparam int ADDR_W = 10;
	localparam int MAX_PAYLOAD = 127;

	// ethernet framing and reflected crc32
	localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;
	localparam logic [31:0] CRC_POLY = 32'hEDB88320;
	localparam logic [7:0] PRE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE = 8'hD5;

	// code 2'b11 falls back to a single copy
	typedef enum logic [1:0] {RED_1 = 2'b00, RED_3 = 2'b01, RED_5 = 2'b10} redundancy_e;

	typedef enum logic [1:0] {SFD_HUNT, SFD_PAYLOAD, SFD_SKIP} sfd_state_e;

	typedef enum logic [1:0] {WR_IDLE, WR_STORE, WR_CLOSE, WR_WAIT_VOTE} wr_state_e;

	typedef enum logic [1:0] {V_IDLE, V_READ_LEN, V_READ_BYTE, V_EMIT} vote_state_e;

endpackage

`default_nettype wire
